// File: verilog/isa_pkg.sv
package isa_pkg;

    localparam int XLEN = 32;

    // Sequential fetch step in bytes
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,  // Not a control transfer
        BR_JAL  = 3'd1,  // Direct jump, target pc + offset
        BR_JALR = 3'd2,  // Register jump, target src_a
        BR_BEQ  = 3'd3,
        BR_BNE  = 3'd4
    } br_kind_t;

    typedef struct packed {
        br_kind_t        kind;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] offset;       // Immediate for jal and conditional branches
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        logic            pred_taken;   // Direction chosen at fetch
        logic [XLEN-1:0] pred_target;  // Only meaningful when pred_taken
    } instr_t;

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    // Instruction buffer geometry
    localparam int IBUF_DEPTH = 8;
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_W = $clog2(IBUF_DEPTH + 1);
    localparam logic [IBUF_CNT_W-1:0] IBUF_FULL = IBUF_CNT_W'(IBUF_DEPTH);
    localparam logic [IBUF_PTR_W-1:0] IBUF_LAST = IBUF_PTR_W'(IBUF_DEPTH - 1);

    typedef struct packed {
        logic             valid;  // Low marks a bubble
        isa_pkg::instr_t  instr;
    } slot_t;

    // Slot a is the older instruction of the pair
    typedef struct packed {
        slot_t a;
        slot_t b;
    } pair_t;

    typedef struct packed {
        logic                      mistaken;
        logic                      taken;   // Actual direction
        logic [isa_pkg::XLEN-1:0]  target;  // Actual target when taken
        logic [isa_pkg::XLEN-1:0]  pc;
    } br_result_t;

    typedef struct packed {
        logic ibuf;
        logic id;
        logic ro;
        logic ex;
    } flush_t;

endpackage

// File: verilog/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  pipe_pkg::pair_t in_pair,
    input  logic            flush_ibuf,
    output pipe_pkg::pair_t head_pair,
    output logic            full
);

    pipe_pkg::pair_t mem [pipe_pkg::IBUF_DEPTH];

    logic [pipe_pkg::IBUF_PTR_W-1:0] wr_ptr;
    logic [pipe_pkg::IBUF_PTR_W-1:0] rd_ptr;
    logic [pipe_pkg::IBUF_CNT_W-1:0] count;
    logic                            empty;
    logic                            do_push;
    logic                            do_pop;

    assign empty   = (count == '0);
    assign full    = (count == pipe_pkg::IBUF_FULL);
    assign do_push = push && !full && !flush_ibuf;  // Push under flush is dropped
    assign do_pop  = !empty && !flush_ibuf;

    // ID takes the head every cycle, so a held-back head becomes a bubble
    assign head_pair = do_pop ? mem[rd_ptr] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_ibuf) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == pipe_pkg::IBUF_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == pipe_pkg::IBUF_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= in_pair;
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !full
    ) else $error("inst_buffer: push while full");

endmodule

// File: verilog/stage_slice.sv
`timescale 1ns/1ps

module stage_slice #(
    parameter bit RESOLVE_JAL  = 1'b0,
    parameter bit RESOLVE_JALR = 1'b0,
    parameter bit RESOLVE_COND = 1'b0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe_pkg::pair_t      in_pair,
    input  logic                 flush,
    output pipe_pkg::pair_t      cur_pair,
    output pipe_pkg::pair_t      out_pair,
    output pipe_pkg::br_result_t res_a,
    output pipe_pkg::br_result_t res_b
);

    logic            valid_a_q;
    logic            valid_b_q;
    isa_pkg::instr_t instr_a_q;
    isa_pkg::instr_t instr_b_q;

    // Actual outcome of one slot, mistaken only for kinds resolved here
    function automatic pipe_pkg::br_result_t resolve(input pipe_pkg::slot_t s);
        pipe_pkg::br_result_t r;
        logic                 hit;
        logic                 dir_wrong;
        logic                 tgt_wrong;
        r        = '0;
        r.pc     = s.instr.pc;
        hit      = 1'b0;
        case (s.instr.kind)
            isa_pkg::BR_JAL: begin
                hit      = RESOLVE_JAL;
                r.taken  = 1'b1;
                r.target = s.instr.pc + s.instr.offset;
            end
            isa_pkg::BR_JALR: begin
                hit      = RESOLVE_JALR;
                r.taken  = 1'b1;
                r.target = s.instr.src_a;
            end
            isa_pkg::BR_BEQ: begin
                hit      = RESOLVE_COND;
                r.taken  = (s.instr.src_a == s.instr.src_b);
                r.target = s.instr.pc + s.instr.offset;
            end
            isa_pkg::BR_BNE: begin
                hit      = RESOLVE_COND;
                r.taken  = (s.instr.src_a != s.instr.src_b);
                r.target = s.instr.pc + s.instr.offset;
            end
            default: begin
                hit      = 1'b0;
                r.taken  = 1'b0;
                r.target = '0;
            end
        endcase
        dir_wrong  = (r.taken != s.instr.pred_taken);
        tgt_wrong  = r.taken && (r.target != s.instr.pred_target);
        r.mistaken = s.valid && hit && (dir_wrong || tgt_wrong);
        return r;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_a_q <= 1'b0;
            valid_b_q <= 1'b0;
        end else if (flush) begin
            valid_a_q <= 1'b0;  // Load a bubble
            valid_b_q <= 1'b0;
        end else begin
            valid_a_q <= in_pair.a.valid;
            valid_b_q <= in_pair.b.valid;
        end
    end

    always_ff @(posedge clk) begin
        instr_a_q <= in_pair.a.instr;
        instr_b_q <= in_pair.b.instr;
    end

    assign cur_pair.a.valid = valid_a_q;
    assign cur_pair.a.instr = instr_a_q;
    assign cur_pair.b.valid = valid_b_q;
    assign cur_pair.b.instr = instr_b_q;

    assign res_a = resolve(cur_pair.a);
    assign res_b = resolve(cur_pair.b);

    always_comb begin
        out_pair = cur_pair;
        if (res_a.mistaken) begin
            out_pair.b.valid = 1'b0;  // Younger slot is on the wrong path
        end
    end

    a_mistake_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_a.mistaken |-> cur_pair.a.valid) and (res_b.mistaken |-> cur_pair.b.valid)
    ) else $error("stage_slice: mistaken result from an empty slot");

endmodule

// File: verilog/branch_ctrl.sv
`timescale 1ns/1ps

module branch_ctrl (
    input  pipe_pkg::br_result_t      id_a,
    input  pipe_pkg::br_result_t      id_b,
    input  pipe_pkg::br_result_t      ro_a,
    input  pipe_pkg::br_result_t      ro_b,
    input  pipe_pkg::br_result_t      ex_a,
    input  pipe_pkg::br_result_t      ex_b,
    output logic                      redirect,
    output logic [isa_pkg::XLEN-1:0]  correct_target,
    output pipe_pkg::flush_t          flush
);

    // Index 0 is the oldest slot in the pipeline
    pipe_pkg::br_result_t [5:0] results;
    pipe_pkg::br_result_t       win;
    logic [2:0]                 win_idx;
    logic                       win_in_ex;
    logic                       win_in_ro;

    assign results = {id_b, id_a, ro_b, ro_a, ex_b, ex_a};

    always_comb begin
        redirect = 1'b0;
        win      = '0;
        win_idx  = '0;
        for (int i = 0; i < 6; i++) begin
            if (!redirect && results[i].mistaken) begin
                redirect = 1'b1;
                win      = results[i];
                win_idx  = 3'(i);
            end
        end
    end

    assign win_in_ex = redirect && (win_idx < 3'd2);
    assign win_in_ro = redirect && (win_idx >= 3'd2) && (win_idx < 3'd4);

    always_comb begin
        if (!redirect) begin
            correct_target = '0;
        end else if (win.taken) begin
            correct_target = win.target;
        end else begin
            correct_target = win.pc + isa_pkg::INSTR_BYTES;  // Fall through
        end
    end

    // Everything younger than the winner goes, the winner itself moves on
    assign flush.ex   = win_in_ex;
    assign flush.ro   = win_in_ex || win_in_ro;
    assign flush.id   = win_in_ex || win_in_ro;
    assign flush.ibuf = redirect;

    always_comb begin
        a_ex_implies_ro: assert final (!flush.ex || flush.ro)
            else $error("branch_ctrl: EX flush without RO flush");
        a_ro_implies_id: assert final (!flush.ro || flush.id)
            else $error("branch_ctrl: RO flush without ID flush");
        a_any_implies_ibuf: assert final (!(|flush) || flush.ibuf)
            else $error("branch_ctrl: flush without buffer flush");
    end

endmodule

// File: verilog/dual_pipe_top.sv
`timescale 1ns/1ps

module dual_pipe_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  pipe_pkg::pair_t           in_pair,
    output logic                      full,
    output pipe_pkg::pair_t           retire_pair,
    output logic                      redirect,
    output logic [isa_pkg::XLEN-1:0]  correct_target,
    output pipe_pkg::flush_t          flush
);

    pipe_pkg::pair_t      head_pair;
    pipe_pkg::pair_t      id_out;
    pipe_pkg::pair_t      ro_out;
    pipe_pkg::br_result_t id_res_a;
    pipe_pkg::br_result_t id_res_b;
    pipe_pkg::br_result_t ro_res_a;
    pipe_pkg::br_result_t ro_res_b;
    pipe_pkg::br_result_t ex_res_a;
    pipe_pkg::br_result_t ex_res_b;

    inst_buffer inst_buffer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .in_pair    (in_pair),
        .flush_ibuf (flush.ibuf),
        .head_pair  (head_pair),
        .full       (full)
    );

    // Stage contents stay reachable by hierarchy for debug
    stage_slice #(
        .RESOLVE_JAL  (1'b1),
        .RESOLVE_JALR (1'b0),
        .RESOLVE_COND (1'b0)
    ) id_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_pair  (head_pair),
        .flush    (flush.id),
        .cur_pair (),
        .out_pair (id_out),
        .res_a    (id_res_a),
        .res_b    (id_res_b)
    );

    stage_slice #(
        .RESOLVE_JAL  (1'b0),
        .RESOLVE_JALR (1'b1),
        .RESOLVE_COND (1'b0)
    ) ro_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_pair  (id_out),
        .flush    (flush.ro),
        .cur_pair (),
        .out_pair (ro_out),
        .res_a    (ro_res_a),
        .res_b    (ro_res_b)
    );

    stage_slice #(
        .RESOLVE_JAL  (1'b0),
        .RESOLVE_JALR (1'b0),
        .RESOLVE_COND (1'b1)
    ) ex_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_pair  (ro_out),
        .flush    (flush.ex),
        .cur_pair (),
        .out_pair (retire_pair),
        .res_a    (ex_res_a),
        .res_b    (ex_res_b)
    );

    branch_ctrl branch_ctrl_inst (
        .id_a           (id_res_a),
        .id_b           (id_res_b),
        .ro_a           (ro_res_a),
        .ro_b           (ro_res_b),
        .ex_a           (ex_res_a),
        .ex_b           (ex_res_b),
        .redirect       (redirect),
        .correct_target (correct_target),
        .flush          (flush)
    );

endmodule

// File: tests/tb_dual_branch_pipe.sv
`timescale 1ns/1ps

module tb_dual_branch_pipe;

    localparam int CW         = $bits(pipe_pkg::pair_t);
    localparam int SEQ_TICKS  = 10;   // Last push at tick 4 retires at tick 8
    localparam int MAX_CYCLES = 400;  // Six tests of up to forty cycles plus margin

    logic                     clk;
    logic                     rst_n;
    logic                     push;
    pipe_pkg::pair_t          in_pair;
    logic                     full;
    pipe_pkg::pair_t          retire_pair;
    logic                     redirect;
    logic [isa_pkg::XLEN-1:0] correct_target;
    pipe_pkg::flush_t         flush;

    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          fail_count  = 0;

    dual_pipe_top dual_pipe_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (push),
        .in_pair        (in_pair),
        .full           (full),
        .retire_pair    (retire_pair),
        .redirect       (redirect),
        .correct_target (correct_target),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic isa_pkg::instr_t plain_instr();
        isa_pkg::instr_t ins;
        ins             = '0;
        ins.kind        = isa_pkg::BR_NONE;
        ins.pc          = next_random() & 32'hffff_fffc;         // Word aligned
        ins.offset      = (next_random() & 32'h0000_0ffc) + 32'd8; // Never the fall-through
        ins.src_a       = next_random();
        ins.src_b       = next_random();
        ins.pred_taken  = 1'b0;
        ins.pred_target = '0;
        return ins;
    endfunction

    // Branch whose predicted target is the correct one when taken
    function automatic isa_pkg::instr_t branch_instr(
        input isa_pkg::br_kind_t kind,
        input logic              ops_equal,
        input logic              pred_taken
    );
        isa_pkg::instr_t ins;
        ins            = plain_instr();
        ins.kind       = kind;
        ins.src_b      = ops_equal ? ins.src_a : ~ins.src_a;
        ins.pred_taken = pred_taken;
        if (kind == isa_pkg::BR_JALR) begin
            ins.pred_target = ins.src_a;
        end else begin
            ins.pred_target = ins.pc + ins.offset;
        end
        return ins;
    endfunction

    function automatic pipe_pkg::pair_t make_pair(
        input isa_pkg::instr_t ia,
        input isa_pkg::instr_t ib
    );
        pipe_pkg::pair_t p;
        p.a.valid = 1'b1;
        p.a.instr = ia;
        p.b.valid = 1'b1;
        p.b.instr = ib;
        return p;
    endfunction

    task automatic compare(
        input string         what,
        input logic [CW-1:0] expected,
        input logic [CW-1:0] actual
    );
        if (expected !== actual) begin
            fail_count++;
            $display("MISMATCH %s expected=%0h actual=%0h", what, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic drive(input logic en, input pipe_pkg::pair_t p);
        push    = en;
        in_pair = en ? p : '0;
    endtask

    // Instruction fields only matter for valid slots
    task automatic expect_retire(input string name, input pipe_pkg::pair_t exp);
        compare({name, " retire a.valid"}, exp.a.valid, retire_pair.a.valid);
        compare({name, " retire b.valid"}, exp.b.valid, retire_pair.b.valid);
        if (exp.a.valid) begin
            compare({name, " retire a.instr"}, exp.a.instr, retire_pair.a.instr);
        end
        if (exp.b.valid) begin
            compare({name, " retire b.instr"}, exp.b.instr, retire_pair.b.instr);
        end
    endtask

    task automatic expect_quiet(input string name);
        compare({name, " redirect"}, 1'b0, redirect);
        compare({name, " flush"}, 4'b0000, flush);
    endtask

    task automatic expect_redirect(
        input string                    name,
        input logic [isa_pkg::XLEN-1:0] target,
        input pipe_pkg::flush_t         flush_exp
    );
        compare({name, " redirect"}, 1'b1, redirect);
        compare({name, " correct_target"}, target, correct_target);
        compare({name, " flush"}, flush_exp, flush);
    endtask

    // Pushes go in at ticks 0, 1, ... and retires are expected from tick 4 on
    task automatic run_sequence(
        input string                    name,
        input pipe_pkg::pair_t          pushes [$],
        input pipe_pkg::pair_t          retires [$],
        input int                       redirect_tick,
        input logic [isa_pkg::XLEN-1:0] target,
        input pipe_pkg::flush_t         flush_exp
    );
        pipe_pkg::pair_t exp;
        for (int t = 0; t < SEQ_TICKS; t++) begin
            next_cycle();
            exp = '0;
            if (t >= 4 && t - 4 < retires.size()) begin
                exp = retires[t - 4];
            end
            expect_retire(name, exp);
            compare({name, " full"}, 1'b0, full);
            if (t == redirect_tick) begin
                expect_redirect(name, target, flush_exp);
            end else begin
                expect_quiet(name);
            end
            if (t < pushes.size()) begin
                drive(1'b1, pushes[t]);
            end else begin
                drive(1'b0, '0);
            end
        end
    endtask

    task automatic straight_line_flow();
        pipe_pkg::pair_t p [$];
        for (int i = 0; i < 3; i++) begin
            p.push_back(make_pair(plain_instr(), plain_instr()));
        end
        run_sequence("straight_line_flow", p, p, -1, '0, '0);
    endtask

    task automatic jal_miss_in_id();
        isa_pkg::instr_t  j;
        pipe_pkg::pair_t  kept;
        pipe_pkg::pair_t  pushes [$];
        pipe_pkg::pair_t  retires [$];
        pipe_pkg::flush_t fl;
        j    = branch_instr(isa_pkg::BR_JAL, 1'b0, 1'b0);  // Predicted not taken
        kept = make_pair(j, plain_instr());
        pushes.push_back(kept);
        pushes.push_back(make_pair(plain_instr(), plain_instr()));  // Still in the buffer
        pushes.push_back(make_pair(plain_instr(), plain_instr()));  // Same cycle as the flush
        kept.b.valid = 1'b0;
        retires.push_back(kept);
        fl      = '0;
        fl.ibuf = 1'b1;
        run_sequence("jal_miss_in_id", pushes, retires, 2, j.pc + j.offset, fl);
    endtask

    task automatic jalr_miss_in_ro();
        isa_pkg::instr_t  j;
        pipe_pkg::pair_t  older;
        pipe_pkg::pair_t  jp;
        pipe_pkg::pair_t  pushes [$];
        pipe_pkg::pair_t  retires [$];
        pipe_pkg::flush_t fl;
        j             = branch_instr(isa_pkg::BR_JALR, 1'b0, 1'b1);
        j.pred_target = j.src_a + 32'd16;  // Wrong target
        older         = make_pair(plain_instr(), plain_instr());
        jp            = make_pair(plain_instr(), j);
        pushes.push_back(older);
        pushes.push_back(jp);
        for (int i = 0; i < 3; i++) begin
            pushes.push_back(make_pair(plain_instr(), plain_instr()));
        end
        retires.push_back(older);
        retires.push_back(jp);
        fl      = '0;
        fl.ibuf = 1'b1;
        fl.id   = 1'b1;
        fl.ro   = 1'b1;
        run_sequence("jalr_miss_in_ro", pushes, retires, 4, j.src_a, fl);
    endtask

    task automatic cond_miss_in_ex();
        isa_pkg::instr_t  c;
        pipe_pkg::pair_t  kept;
        pipe_pkg::pair_t  pushes [$];
        pipe_pkg::pair_t  retires [$];
        c    = branch_instr(isa_pkg::BR_BEQ, 1'b0, 1'b1);  // Unequal operands
        kept = make_pair(c, plain_instr());
        pushes.push_back(kept);
        for (int i = 0; i < 4; i++) begin
            pushes.push_back(make_pair(plain_instr(), plain_instr()));
        end
        kept.b.valid = 1'b0;
        retires.push_back(kept);
        run_sequence("cond_miss_in_ex", pushes, retires, 4, c.pc + 32'd4, 4'b1111);
    endtask

    task automatic ex_beats_id();
        isa_pkg::instr_t  c;
        isa_pkg::instr_t  j;
        pipe_pkg::pair_t  cp;
        pipe_pkg::pair_t  pushes [$];
        pipe_pkg::pair_t  retires [$];
        c             = branch_instr(isa_pkg::BR_BNE, 1'b0, 1'b0);  // Taken, predicted not
        j             = branch_instr(isa_pkg::BR_JAL, 1'b0, 1'b1);
        j.pred_target = j.pred_target + 32'd4;
        cp            = make_pair(plain_instr(), c);
        pushes.push_back(cp);
        pushes.push_back(make_pair(plain_instr(), plain_instr()));
        pushes.push_back(make_pair(j, plain_instr()));  // Reaches ID as cp reaches EX
        retires.push_back(cp);
        run_sequence("ex_beats_id", pushes, retires, 4, c.pc + c.offset, 4'b1111);
    endtask

    task automatic correct_predictions();
        pipe_pkg::pair_t p [$];
        p.push_back(make_pair(branch_instr(isa_pkg::BR_JAL, 1'b0, 1'b1),
                              branch_instr(isa_pkg::BR_BEQ, 1'b1, 1'b1)));
        p.push_back(make_pair(branch_instr(isa_pkg::BR_JALR, 1'b0, 1'b1),
                              branch_instr(isa_pkg::BR_BNE, 1'b1, 1'b0)));
        p.push_back(make_pair(branch_instr(isa_pkg::BR_BEQ, 1'b0, 1'b0),
                              branch_instr(isa_pkg::BR_BNE, 1'b0, 1'b1)));
        run_sequence("correct_predictions", p, p, -1, '0, '0);
    endtask

    initial begin
        lcg_state = 32'h90c2;
        rst_n     = 1'b0;
        push      = 1'b0;
        in_pair   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        expect_retire("reset", '0);
        expect_quiet("reset");
        compare("reset full", 1'b0, full);
        rst_n = 1'b1;

        straight_line_flow();
        jal_miss_in_id();
        jalr_miss_in_ro();
        cond_miss_in_ex();
        ex_beats_id();
        correct_predictions();

        if (fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "errors were found");
        end
    end

endmodule

// File: dual_branch_pipe.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_buffer.sv
verilog/stage_slice.sv
verilog/branch_ctrl.sv
verilog/dual_pipe_top.sv
tests/tb_dual_branch_pipe.sv
